// ==== hw/isaPkg.sv ====
// Instruction encodings and stage payload types, imported by every pipeline stage
`default_nettype none

package isaPkg;

	localparam int NumRegs = 32;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regIdx_t;

	typedef enum logic [5:0] {
		opR    = 6'h00,
		opBeq  = 6'h04,
		opAddi = 6'h08,
		opLw   = 6'h23,
		opSw   = 6'h2b,
		opHalt = 6'h3f
	} opcode_t;

	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp_t;

	typedef struct packed {
		opcode_t opcode;
		regIdx_t rs;
		regIdx_t rt;
		regIdx_t rd;
		logic [4:0] shamt;
		funct_t funct;
	} rType_t;

	typedef struct packed {
		opcode_t opcode;
		regIdx_t rs;
		regIdx_t rt;
		logic [15:0] imm;
	} iType_t;

	// Opcode, rs and rt sit at the same bits in both views
	typedef union packed {
		rType_t rType;
		iType_t iType;
	} instr_t;

	typedef struct packed {
		logic valid;
		aluOp_t aluOp;
		logic useImm, isLoad, isStore, isBranch, isHalt, writeEn;
		regIdx_t rs, rt, rd;
		word_t rsVal, rtVal, imm, nextPc;
	} decEx_t;

	typedef struct packed {
		logic valid;
		logic isLoad, isStore, isHalt, writeEn;
		regIdx_t rd;
		word_t result, storeData;
	} exMem_t;

	typedef struct packed {
		logic writeEn;
		regIdx_t rd;
		word_t data;
	} memWb_t;

	typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSel_t;

endpackage

`default_nettype wire

// ==== hw/busPkg.sv ====
// Request and response types of the shared memory bus, used by both requesters and the arbiter
`default_nettype none

package busPkg;

	localparam int AddrWidth = 32;
	localparam int DataWidth = 32;

	typedef logic [AddrWidth-1:0] addr_t;

	// Held stable from valid until the cycle with ready
	typedef struct packed {
		logic valid;
		logic write;
		addr_t addr;
		logic [DataWidth-1:0] wdata;
	} memReq_t;

	typedef struct packed {
		logic ready;
		logic [DataWidth-1:0] rdata;
	} memRsp_t;

endpackage

`default_nettype wire

// ==== hw/fetchUnit.sv ====
// Fetch stage; reads instructions over the memory bus and fills the fetch/decode register
`default_nettype none
`timescale 1ns/100ps

module fetchUnit (
	input wire clk,
	input wire rst_n,
	output busPkg::memReq_t req,
	input wire busPkg::memRsp_t rsp,
	input wire stall,
	input wire hold,
	input wire redirect,
	input wire isaPkg::word_t target,
	input wire halted,
	output isaPkg::instr_t instr,
	output logic instrValid,
	output isaPkg::word_t nextPc
);
	import isaPkg::*;
	import busPkg::*;

	word_t pc, pcPlus4, pcNext;
	addr_t fetchAddr;
	logic inFlight, stale;
	logic done, useWord;

	assign done = inFlight && rsp.ready;
	// A word is kept only on the current path and when decode can take it
	assign useWord = done && !stale && !redirect && !stall && !hold;
	assign pcPlus4 = pc + 32'd4;
	assign pcNext = redirect ? target : (useWord ? pcPlus4 : pc);

	assign req.valid = inFlight;
	assign req.write = 1'b0;
	assign req.addr = fetchAddr;
	assign req.wdata = '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
			inFlight <= 1'b0;
			stale <= 1'b0;
		end else begin
			pc <= pcNext;
			if (!inFlight || done) begin
				inFlight <= !halted;
				stale <= 1'b0;
			end else if (redirect) begin
				// Old address stays on the bus until ready
				stale <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!inFlight || done) begin
			fetchAddr <= addr_t'(pcNext);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			instrValid <= 1'b0;
		end else if (redirect) begin
			instrValid <= 1'b0;
		end else if (!stall && !hold) begin
			instrValid <= useWord;
		end
	end

	always_ff @(posedge clk) begin
		if (useWord) begin
			instr <= instr_t'(rsp.rdata);
			nextPc <= pcPlus4;
		end
	end

endmodule

`default_nettype wire

// ==== hw/decodeStage.sv ====
// Decode stage with the register file; turns fetched words into the decode/execute payload
`default_nettype none
`timescale 1ns/100ps

module decodeStage (
	input wire clk,
	input wire rst_n,
	input wire isaPkg::instr_t instr,
	input wire instrValid,
	input wire isaPkg::word_t nextPc,
	input wire isaPkg::memWb_t wb,
	input wire stall,
	input wire hold,
	input wire flush,
	output isaPkg::decEx_t out
);
	import isaPkg::*;

	word_t regs [NumRegs];
	decEx_t decoded;

	// Same-cycle write shows through to the read
	function automatic word_t readReg(regIdx_t idx);
		if (idx == '0) begin
			return '0;
		end
		if (wb.writeEn && wb.rd == idx) begin
			return wb.data;
		end
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.writeEn && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	always_comb begin
		decoded = '0;
		decoded.valid = 1'b1;
		decoded.aluOp = aluAdd;
		decoded.rs = instr.rType.rs;
		decoded.rt = instr.rType.rt;
		decoded.rsVal = readReg(instr.rType.rs);
		decoded.rtVal = readReg(instr.rType.rt);
		decoded.imm = {{16{instr.iType.imm[15]}}, instr.iType.imm};
		decoded.nextPc = nextPc;
		case (instr.rType.opcode)
			opR: begin
				decoded.rd = instr.rType.rd;
				decoded.writeEn = 1'b1;
				case (instr.rType.funct)
					fnAdd: decoded.aluOp = aluAdd;
					fnSub: decoded.aluOp = aluSub;
					fnAnd: decoded.aluOp = aluAnd;
					fnOr: decoded.aluOp = aluOr;
					fnSlt: decoded.aluOp = aluSlt;
					default: decoded.writeEn = 1'b0;
				endcase
			end
			opAddi: begin
				decoded.rd = instr.iType.rt;
				decoded.useImm = 1'b1;
				decoded.writeEn = 1'b1;
			end
			opLw: begin
				decoded.rd = instr.iType.rt;
				decoded.useImm = 1'b1;
				decoded.isLoad = 1'b1;
				decoded.writeEn = 1'b1;
			end
			opSw: begin
				decoded.useImm = 1'b1;
				decoded.isStore = 1'b1;
			end
			opBeq: decoded.isBranch = 1'b1;
			opHalt: decoded.isHalt = 1'b1;
			// Unknown opcodes go down the pipe as bubbles
			default: decoded.valid = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out <= '0;
		end else if (!hold) begin
			if (stall || flush || !instrValid) begin
				out <= '0;
			end else begin
				out <= decoded;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/executeStage.sv ====
// Execute stage; forwarded operands, ALU, branch-if-equal resolution and the execute/memory register
`default_nettype none
`timescale 1ns/100ps

module executeStage (
	input wire clk,
	input wire rst_n,
	input wire isaPkg::decEx_t in,
	input wire isaPkg::fwdSel_t fwdA,
	input wire isaPkg::fwdSel_t fwdB,
	input wire isaPkg::exMem_t memFwd,
	input wire isaPkg::memWb_t wbFwd,
	input wire hold,
	output logic taken,
	output isaPkg::word_t target,
	output isaPkg::exMem_t out
);
	import isaPkg::*;

	word_t opA, rtVal, opB, result;

	function automatic word_t pickOperand(fwdSel_t sel, word_t regVal);
		case (sel)
			fwdMem: return memFwd.result;
			fwdWb: return wbFwd.data;
			default: return regVal;
		endcase
	endfunction

	assign opA = pickOperand(fwdA, in.rsVal);
	assign rtVal = pickOperand(fwdB, in.rtVal);
	assign opB = in.useImm ? in.imm : rtVal;

	always_comb begin
		case (in.aluOp)
			aluAdd: result = opA + opB;
			aluSub: result = opA - opB;
			aluAnd: result = opA & opB;
			aluOr: result = opA | opB;
			aluSlt: result = word_t'($signed(opA) < $signed(opB));
			default: result = '0;
		endcase
	end

	// Fetch runs on as if not taken; a hit here redirects it
	assign taken = in.valid && in.isBranch && (opA == rtVal);
	assign target = in.nextPc + (in.imm << 2);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out.valid <= 1'b0;
			out.isLoad <= 1'b0;
			out.isStore <= 1'b0;
			out.isHalt <= 1'b0;
			out.writeEn <= 1'b0;
		end else if (!hold) begin
			out.valid <= in.valid;
			out.isLoad <= in.isLoad;
			out.isStore <= in.isStore;
			out.isHalt <= in.isHalt;
			out.writeEn <= in.valid && in.writeEn;
			out.rd <= in.rd;
			out.result <= result;
			out.storeData <= rtVal;
		end
	end

endmodule

`default_nettype wire

// ==== hw/memoryStage.sv ====
// Memory stage; load and store transfers on the bus, halt detection and the write-back register
`default_nettype none
`timescale 1ns/100ps

module memoryStage (
	input wire clk,
	input wire rst_n,
	input wire isaPkg::exMem_t in,
	output busPkg::memReq_t req,
	input wire busPkg::memRsp_t rsp,
	output logic pending,
	output isaPkg::memWb_t wb,
	output logic halt
);
	import busPkg::*;

	// Nothing younger than a halt reaches the bus
	assign req.valid = in.valid && (in.isLoad || in.isStore) && !halt;
	assign req.write = in.isStore;
	assign req.addr = addr_t'(in.result);
	assign req.wdata = in.storeData;

	assign pending = req.valid && !rsp.ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb.writeEn <= 1'b0;
			halt <= 1'b0;
		end else begin
			if (!pending) begin
				wb.writeEn <= in.valid && in.writeEn;
				wb.rd <= in.rd;
				wb.data <= in.isLoad ? rsp.rdata : in.result;
			end
			if (in.valid && in.isHalt) begin
				halt <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/hazardUnit.sv ====
// Hazard logic; forwarding selects for execute plus the load-use and memory stall levels
`default_nettype none
`timescale 1ns/100ps

module hazardUnit (
	input wire isaPkg::instr_t instr,
	input wire instrValid,
	input wire isaPkg::decEx_t decode,
	input wire isaPkg::exMem_t exMem,
	input wire isaPkg::memWb_t memWb,
	input wire memPending,
	output isaPkg::fwdSel_t fwdA,
	output isaPkg::fwdSel_t fwdB,
	output logic loadStall,
	output logic memStall
);
	import isaPkg::*;

	logic usesRt, rsHit, rtHit;

	// Younger result wins
	function automatic fwdSel_t pickSource(regIdx_t src);
		if (src == '0) begin
			return fwdNone;
		end
		if (exMem.writeEn && exMem.rd == src) begin
			return fwdMem;
		end
		if (memWb.writeEn && memWb.rd == src) begin
			return fwdWb;
		end
		return fwdNone;
	endfunction

	assign fwdA = pickSource(decode.rs);
	assign fwdB = pickSource(decode.rt);

	// For addi and lw the rt field is a destination
	assign usesRt = instr.rType.opcode inside {opR, opSw, opBeq};
	assign rsHit = decode.rd == instr.rType.rs;
	assign rtHit = usesRt && decode.rd == instr.rType.rt;

	assign loadStall = instrValid && decode.valid && decode.isLoad && decode.writeEn &&
		decode.rd != '0 && (rsHit || rtHit);
	assign memStall = memPending;

endmodule

`default_nettype wire

// ==== hw/busArbiter.sv ====
// Shares one memory bus between the data and fetch requesters, data first between transfers
`default_nettype none
`timescale 1ns/100ps

module busArbiter (
	input wire clk,
	input wire rst_n,
	input wire busPkg::memReq_t dataReq,
	output busPkg::memRsp_t dataRsp,
	input wire busPkg::memReq_t fetchReq,
	output busPkg::memRsp_t fetchRsp,
	output busPkg::memReq_t memReq,
	input wire busPkg::memRsp_t memRsp
);
	logic locked, ownerData, grantData;

	// An open transfer keeps its owner
	assign grantData = locked ? ownerData : dataReq.valid;
	assign memReq = grantData ? dataReq : fetchReq;

	assign dataRsp.ready = grantData && dataReq.valid && memRsp.ready;
	assign dataRsp.rdata = grantData ? memRsp.rdata : '0;
	assign fetchRsp.ready = !grantData && fetchReq.valid && memRsp.ready;
	assign fetchRsp.rdata = grantData ? '0 : memRsp.rdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			locked <= 1'b0;
			ownerData <= 1'b0;
		end else begin
			locked <= memReq.valid && !memRsp.ready;
			ownerData <= grantData;
		end
	end

endmodule

`default_nettype wire

// ==== hw/pipelineCpu.sv ====
// Top of the five-stage processor; connects the stages, hazard logic and bus arbiter
`default_nettype none
`timescale 1ns/100ps

module pipelineCpu (
	input wire clk,
	input wire rst_n,
	output busPkg::memReq_t memReq,
	input wire busPkg::memRsp_t memRsp,
	output logic halt
);
	import isaPkg::*;
	import busPkg::*;

	memReq_t fetchReq, dataReq;
	memRsp_t fetchRsp, dataRsp;
	instr_t fdInstr;
	logic fdValid;
	word_t fdNextPc, target;
	decEx_t idEx;
	exMem_t exMem;
	memWb_t memWb;
	fwdSel_t fwdA, fwdB;
	logic loadStall, memStall, memPending, taken;

	fetchUnit fetch0 (
		.clk(clk), .rst_n(rst_n),
		.req(fetchReq), .rsp(fetchRsp),
		.stall(loadStall), .hold(memStall),
		.redirect(taken), .target(target), .halted(halt),
		.instr(fdInstr), .instrValid(fdValid), .nextPc(fdNextPc)
	);

	decodeStage decode0 (
		.clk(clk), .rst_n(rst_n),
		.instr(fdInstr), .instrValid(fdValid), .nextPc(fdNextPc),
		.wb(memWb),
		.stall(loadStall), .hold(memStall), .flush(taken),
		.out(idEx)
	);

	executeStage execute0 (
		.clk(clk), .rst_n(rst_n),
		.in(idEx), .fwdA(fwdA), .fwdB(fwdB),
		.memFwd(exMem), .wbFwd(memWb),
		.hold(memStall),
		.taken(taken), .target(target),
		.out(exMem)
	);

	memoryStage memory0 (
		.clk(clk), .rst_n(rst_n),
		.in(exMem),
		.req(dataReq), .rsp(dataRsp),
		.pending(memPending),
		.wb(memWb), .halt(halt)
	);

	hazardUnit hazard0 (
		.instr(fdInstr), .instrValid(fdValid),
		.decode(idEx), .exMem(exMem), .memWb(memWb),
		.memPending(memPending),
		.fwdA(fwdA), .fwdB(fwdB),
		.loadStall(loadStall), .memStall(memStall)
	);

	busArbiter arbiter0 (
		.clk(clk), .rst_n(rst_n),
		.dataReq(dataReq), .dataRsp(dataRsp),
		.fetchReq(fetchReq), .fetchRsp(fetchRsp),
		.memReq(memReq), .memRsp(memRsp)
	);

endmodule

`default_nettype wire

// ==== bench/tbClock.sv ====
// Testbench clock and reset source; call applyReset to restart the processor
`default_nettype none
`timescale 1ns/100ps

module tbClock (
	output logic clk,
	output logic rst_n
);
	localparam int HalfPeriod = 4;

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		forever #HalfPeriod clk = ~clk;
	end

	// Low for two rising edges, changed just after an edge
	task automatic applyReset();
		@(posedge clk);
		#1 rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
	endtask

endmodule

`default_nettype wire

// ==== bench/tbMemory.sv ====
// Word memory model for the testbench; answers bus requests, optionally with random wait states
`default_nettype none
`timescale 1ns/100ps

module tbMemory (
	input wire clk,
	input wire rst_n,
	input wire randomWaits,
	input wire busPkg::memReq_t req,
	output busPkg::memRsp_t rsp,
	output logic wrote,
	output busPkg::memReq_t wroteReq,
	output logic busError
);
	import busPkg::*;

	localparam int Depth = 256;

	logic [31:0] words [Depth];
	logic [31:0] rngState;
	memReq_t heldReq;
	logic busy, inReset;
	int waitLeft;

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic clearWords();
		for (int i = 0; i < Depth; i++) begin
			words[i] = '0;
		end
	endtask

	task automatic loadWord(int index, logic [31:0] data);
		words[index] = data;
	endtask

	initial begin
		rsp = '0;
		wrote = 1'b0;
		wroteReq = '0;
		busError = 1'b0;
		busy = 1'b0;
		waitLeft = 0;
		rngState = 32'd66;
	end

	always @(posedge clk) begin
		inReset = !rst_n;
		#1;
		rsp = '0;
		wrote = 1'b0;
		if (inReset) begin
			busy = 1'b0;
		end else if (busy && req !== heldReq) begin
			$display("Bus request for addr %h changed to addr %h before it was accepted",
				heldReq.addr, req.addr);
			busError = 1'b1;
		end else if (req.valid) begin
			if (!busy) begin
				heldReq = req;
				busy = 1'b1;
				waitLeft = 0;
				if (randomWaits) begin
					rngState = xorshift32(rngState);
					waitLeft = int'(rngState[1:0]);
				end
			end
			if (waitLeft == 0) begin
				rsp.ready = 1'b1;
				busy = 1'b0;
				if (heldReq.write) begin
					words[heldReq.addr[9:2]] = heldReq.wdata;
					wrote = 1'b1;
					wroteReq = heldReq;
				end else begin
					rsp.rdata = words[heldReq.addr[9:2]];
				end
			end else begin
				waitLeft--;
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/tbCpu.sv ====
// Testbench top; runs small programs on the processor and checks the stores seen on the bus
`default_nettype none
`timescale 1ns/100ps

module tbCpu;
	import isaPkg::*;
	import busPkg::*;

	// Cycle budget per test, five tests, four times over
	localparam int TestBudget = 250;
	localparam int TimeoutCycles = 4 * 5 * TestBudget;
	localparam int QuietCycles = 20;

	wire clk;
	wire rst_n;
	logic randomWaits;
	memReq_t memReq, wroteReq;
	memRsp_t memRsp;
	logic halt, wrote, busError;
	memReq_t storeLog[$];
	memReq_t expectedLog[$];
	int progLen;
	int cycles = 0;

	tbClock clk0 (.clk(clk), .rst_n(rst_n));

	tbMemory mem0 (
		.clk(clk), .rst_n(rst_n), .randomWaits(randomWaits),
		.req(memReq), .rsp(memRsp),
		.wrote(wrote), .wroteReq(wroteReq), .busError(busError)
	);

	pipelineCpu dut0 (
		.clk(clk), .rst_n(rst_n),
		.memReq(memReq), .memRsp(memRsp), .halt(halt)
	);

	task automatic abortRun();
		$display("Finished with errors");
		$fatal(1, "Run stopped at the first failure");
	endtask

	function automatic string describeReq(memReq_t r);
		return $sformatf("valid %b write %b addr %h data %h", r.valid, r.write, r.addr, r.wdata);
	endfunction

	task automatic checkReq(memReq_t got, memReq_t exp, string what);
		if (got !== exp) begin
			$display("ERROR at %0t: %s: got %s, expected %s", $time, what,
				describeReq(got), describeReq(exp));
			abortRun();
		end
	endtask

	task automatic checkHalt(logic got, logic exp, string what);
		if (got !== exp) begin
			$display("ERROR at %0t: %s: halt is %b, expected %b", $time, what, got, exp);
			abortRun();
		end
	endtask

	function automatic memReq_t makeReq(logic write, addr_t addr, word_t data);
		memReq_t r;
		r.valid = 1'b1;
		r.write = write;
		r.addr = addr;
		r.wdata = data;
		return r;
	endfunction

	function automatic instr_t encodeR(funct_t fn, regIdx_t rd, regIdx_t rs, regIdx_t rt);
		instr_t w;
		w.rType.opcode = opR;
		w.rType.rs = rs;
		w.rType.rt = rt;
		w.rType.rd = rd;
		w.rType.shamt = '0;
		w.rType.funct = fn;
		return w;
	endfunction

	function automatic instr_t encodeI(opcode_t op, regIdx_t rt, regIdx_t rs, logic [15:0] imm);
		instr_t w;
		w.iType.opcode = op;
		w.iType.rs = rs;
		w.iType.rt = rt;
		w.iType.imm = imm;
		return w;
	endfunction

	task automatic startProgram();
		mem0.clearWords();
		progLen = 0;
		expectedLog.delete();
	endtask

	task automatic appendInstr(instr_t w);
		mem0.loadWord(progLen, w);
		progLen++;
	endtask

	task automatic expectStore(addr_t addr, word_t data);
		expectedLog.push_back(makeReq(1'b1, addr, data));
	endtask

	// Reset, check the first fetch, run to halt, then watch a quiet bus
	task automatic runProgram(logic randomMode);
		randomWaits = randomMode;
		storeLog.delete();
		clk0.applyReset();
		@(negedge clk);
		checkHalt(halt, 1'b0, "halt after reset");
		while (!memReq.valid) @(negedge clk);
		checkReq(memReq, makeReq(1'b0, '0, '0), "first request after reset");
		while (!halt) @(negedge clk);
		// A fetch already accepted may still finish
		while (memReq.valid) @(negedge clk);
		repeat (QuietCycles) begin
			@(negedge clk);
			checkHalt(halt, 1'b1, "halt level after halting");
			if (memReq.valid) begin
				$display("Bus request at addr %h after the processor halted", memReq.addr);
				abortRun();
			end
		end
	endtask

	task automatic compareStores();
		for (int i = 0; i < expectedLog.size() && i < storeLog.size(); i++) begin
			checkReq(storeLog[i], expectedLog[i], $sformatf("store %0d", i));
		end
		if (storeLog.size() != expectedLog.size()) begin
			$display("Saw %0d stores on the bus, expected %0d", storeLog.size(),
				expectedLog.size());
			abortRun();
		end
	endtask

	task automatic testArithmetic(logic randomMode);
		word_t a, b;
		a = 32'd7;
		b = -32'sd22;
		startProgram();
		appendInstr(encodeI(opAddi, 1, 0, a[15:0]));
		appendInstr(encodeI(opAddi, 2, 0, b[15:0]));
		appendInstr(encodeR(fnAdd, 3, 1, 2));
		appendInstr(encodeI(opSw, 3, 0, 16'h100));
		appendInstr(encodeR(fnSub, 4, 1, 3));
		appendInstr(encodeR(fnAnd, 5, 4, 1));
		appendInstr(encodeR(fnOr, 6, 5, 2));
		appendInstr(encodeR(fnSlt, 7, 2, 1));
		appendInstr(encodeR(fnSlt, 8, 1, 2));
		appendInstr(encodeI(opSw, 4, 0, 16'h104));
		appendInstr(encodeI(opSw, 5, 0, 16'h108));
		appendInstr(encodeI(opSw, 6, 0, 16'h10c));
		appendInstr(encodeI(opSw, 7, 0, 16'h110));
		appendInstr(encodeI(opSw, 8, 0, 16'h114));
		appendInstr(encodeI(opHalt, 0, 0, 16'h0));
		// 7 + -22, 7 - -15, 22 & 7, 6 | -22
		expectStore(32'h100, 32'hffff_fff1);
		expectStore(32'h104, 32'h0000_0016);
		expectStore(32'h108, 32'h0000_0006);
		expectStore(32'h10c, 32'hffff_ffee);
		expectStore(32'h110, 32'd1);
		expectStore(32'h114, 32'd0);
		runProgram(randomMode);
		compareStores();
	endtask

	task automatic testLoadUse();
		word_t first, second;
		first = 32'h1234_5678;
		second = 32'h8765_4321;
		startProgram();
		mem0.loadWord(32'h180 >> 2, first);
		mem0.loadWord(32'h184 >> 2, second);
		appendInstr(encodeI(opLw, 1, 0, 16'h180));
		appendInstr(encodeI(opAddi, 2, 1, 16'd1));
		appendInstr(encodeI(opSw, 2, 0, 16'h100));
		appendInstr(encodeI(opLw, 3, 0, 16'h184));
		appendInstr(encodeI(opSw, 3, 0, 16'h104));
		appendInstr(encodeI(opHalt, 0, 0, 16'h0));
		expectStore(32'h100, 32'h1234_5679);
		expectStore(32'h104, second);
		runProgram(1'b0);
		compareStores();
	endtask

	task automatic testBranches();
		startProgram();
		appendInstr(encodeI(opAddi, 1, 0, 16'd5));
		appendInstr(encodeI(opAddi, 2, 0, 16'd5));
		// Taken, lands two words past the next one
		appendInstr(encodeI(opBeq, 2, 1, 16'd2));
		appendInstr(encodeI(opSw, 1, 0, 16'h100));
		appendInstr(encodeI(opSw, 2, 0, 16'h104));
		appendInstr(encodeI(opAddi, 3, 0, 16'd9));
		appendInstr(encodeI(opBeq, 3, 1, 16'd1));
		appendInstr(encodeI(opSw, 3, 0, 16'h108));
		appendInstr(encodeI(opHalt, 0, 0, 16'h0));
		expectStore(32'h108, 32'd9);
		runProgram(1'b0);
		compareStores();
	endtask

	task automatic testHalt();
		startProgram();
		appendInstr(encodeI(opAddi, 1, 0, 16'd3));
		appendInstr(encodeI(opSw, 1, 0, 16'h100));
		appendInstr(encodeI(opHalt, 0, 0, 16'h0));
		appendInstr(encodeI(opSw, 1, 0, 16'h104));
		appendInstr(encodeI(opAddi, 2, 0, 16'd4));
		appendInstr(encodeI(opSw, 2, 0, 16'h108));
		expectStore(32'h100, 32'd3);
		runProgram(1'b0);
		compareStores();
	endtask

	always @(negedge clk) begin
		if (wrote) begin
			storeLog.push_back(wroteReq);
		end
		if (busError) begin
			abortRun();
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TimeoutCycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
			abortRun();
		end
	end

	initial begin
		randomWaits = 1'b0;
		progLen = 0;
		testArithmetic(1'b0);
		testLoadUse();
		testBranches();
		// Same program under back-pressure gives the same log
		testArithmetic(1'b1);
		testHalt();
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
hw/isaPkg.sv
hw/busPkg.sv
hw/fetchUnit.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/hazardUnit.sv
hw/busArbiter.sv
hw/pipelineCpu.sv
bench/tbClock.sv
bench/tbMemory.sv
bench/tbCpu.sv

// ==== Bender.yml ====
package:
  name: pipeline_cpu

sources:
  - files:
      - hw/isaPkg.sv
      - hw/busPkg.sv
      - hw/fetchUnit.sv
      - hw/decodeStage.sv
      - hw/executeStage.sv
      - hw/memoryStage.sv
      - hw/hazardUnit.sv
      - hw/busArbiter.sv
      - hw/pipelineCpu.sv
  - target: test
    files:
      - bench/tbClock.sv
      - bench/tbMemory.sv
      - bench/tbCpu.sv
